/* Makefile */
TOP = w3d_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

/* flist.f */
src/gfx_pkg.sv
src/gfx_lane_alu.sv
src/gfx_shader_fpint.sv
src/gfx_raster_scan.sv
src/gfx_raster_fsm.sv
src/gfx_raster.sv
src/w3d_top.sv
sim/w3d_tb.sv

/* sim/w3d_tb.sv */
`timescale 1ns/1ps

module w3d_tb;

	localparam int PERIOD = 40;
	localparam int SH_ROWS = 16;
	localparam int RS_ROWS = 7;

	typedef struct packed {
		gfx_pkg::lane_opcode op;
		gfx_pkg::word        a;
		gfx_pkg::word        b;
		logic                rnd;
	} shader_row;

	// corners are {y, x} words.
	typedef struct packed {
		gfx_pkg::word lo;
		gfx_pkg::word hi;
		logic [3:0]   fill;
		logic [7:0]   count;
		logic         first_last;
	} raster_row;

	// lane 0 takes a and b from the row unless rnd is set.
	localparam shader_row SH_TAB [SH_ROWS] = '{
		'{gfx_pkg::OP_ADD, 32'h7fffffff, 32'h00000001, 1'b0},
		'{gfx_pkg::OP_SUB, 32'h00000000, 32'h00000001, 1'b0},
		'{gfx_pkg::OP_MIN, 32'hffffffff, 32'h00000001, 1'b0},
		'{gfx_pkg::OP_MAX, 32'h80000000, 32'h7fffffff, 1'b0},
		'{gfx_pkg::OP_ABS, 32'h80000000, 32'h00000000, 1'b0},
		'{gfx_pkg::OP_ABS, 32'hfffffff6, 32'h00000000, 1'b0},
		'{gfx_pkg::OP_SHL, 32'h00000001, 32'h00000021, 1'b0},
		'{gfx_pkg::OP_SHR_U, 32'h80000000, 32'h00000004, 1'b0},
		'{gfx_pkg::OP_SHR_S, 32'h80000000, 32'h00000004, 1'b0},
		'{gfx_pkg::OP_SHR_S, 32'h7ffffff0, 32'h0000001f, 1'b0},
		'{gfx_pkg::OP_CLZ, 32'h00000000, 32'h00000000, 1'b0},
		'{gfx_pkg::OP_CLZ, 32'h00010000, 32'h00000000, 1'b0},
		'{gfx_pkg::OP_ADD, 32'h00000000, 32'h00000000, 1'b1},
		'{gfx_pkg::OP_MIN, 32'h00000000, 32'h00000000, 1'b1},
		'{gfx_pkg::OP_SHR_S, 32'h00000000, 32'h00000000, 1'b1},
		'{gfx_pkg::OP_CLZ, 32'h00000000, 32'h00000000, 1'b1}
	};

	localparam raster_row RS_TAB [RS_ROWS] = '{
		'{32'h0003_0002, 32'h0005_0005, 4'd0, 8'd12, 1'b0},
		'{32'h0000_0000, 32'h0000_0000, 4'd0, 8'd1, 1'b0},
		'{32'h0001_0006, 32'h0002_0004, 4'd0, 8'd0, 1'b0},
		'{32'h0014_000a, 32'h0014_000c, 4'd0, 8'd3, 1'b0},
		'{32'h0001_0001, 32'h0000_0000, 4'd0, 8'd0, 1'b1},
		'{32'h0000_0003, 32'h0001_0004, 4'd2, 8'd4, 1'b0},
		'{32'h0007_0000, 32'h0008_0003, 4'd0, 8'd8, 1'b0}
	};

	logic                clk = 1'b0;
	logic                rst_n = 1'b0;
	gfx_pkg::lane_vec    a = '0;
	gfx_pkg::lane_vec    b = '0;
	gfx_pkg::lane_opcode op = gfx_pkg::OP_ADD;
	logic                in_valid = 1'b0;
	logic                out_valid;
	gfx_pkg::lane_vec    q;
	gfx_pkg::word        geom_tdata = '0;
	logic                geom_tlast = 1'b0;
	logic                geom_tvalid = 1'b0;
	logic                geom_tready;
	logic                raster_tready = 1'b1;
	gfx_pkg::word        raster_tdata;
	logic                raster_tlast;
	logic                raster_tvalid;

	logic [31:0]      lfsr = 32'd84587;
	int               cyc = 0;
	int               errors = 0;
	int               checks = 0;
	int               tests = 0;
	int               failed = 0;
	int               ov_count = 0;
	int               frag_got = 0;
	int               gbeats = 0;
	int               wd_cycles;
	int               e0;
	logic             bp_on = 1'b0;
	logic             scan_flag = 1'b0;
	logic             scan_empty = 1'b0;
	logic             cur_empty;
	logic             stall_prev = 1'b0;
	logic [32:0]      held;
	gfx_pkg::word     ra;
	gfx_pkg::word     rb;
	gfx_pkg::word     bp_bits;
	gfx_pkg::lane_vec ev;
	gfx_pkg::coord    rlo;
	gfx_pkg::coord    rhi;
	string            cur_name = "reset";
	gfx_pkg::lane_vec sh_exp [$];
	int               sh_cyc [$];
	string            sh_name [$];
	gfx_pkg::coord    exp_frag [$];

	w3d_top DUT (.*);

	always #(PERIOD / 2) clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? (s >> 1) ^ 32'h80200003 : s >> 1;
	endfunction

	task automatic take_bits(input int n, output gfx_pkg::word v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic gfx_pkg::word lane_ref(input gfx_pkg::lane_opcode o,
		input gfx_pkg::word x, input gfx_pkg::word y);
		gfx_pkg::word r;
		int           s;
		int           n;
		s = int'(y[4:0]);
		n = 0;
		case (o)
			gfx_pkg::OP_ADD: r = x + y;
			gfx_pkg::OP_SUB: r = x + ~y + 32'd1;
			gfx_pkg::OP_MIN: r = ($signed(x) <= $signed(y)) ? x : y;
			gfx_pkg::OP_MAX: r = ($signed(x) >= $signed(y)) ? x : y;
			gfx_pkg::OP_ABS: r = x[31] ? 32'd0 - x : x;
			gfx_pkg::OP_SHL: r = x << s;
			gfx_pkg::OP_SHR_U: r = x >> s;
			// sign bits fill from the top.
			gfx_pkg::OP_SHR_S: r = (x >> s) | (x[31] ? ~(32'hffffffff >> s) : 32'd0);
			gfx_pkg::OP_CLZ: begin
				while (n < 32 && !x[31 - n])
					n++;
				r = gfx_pkg::word'(n);
			end
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic compare_values(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before) begin
			$display("test %s ok", name);
		end else begin
			failed++;
			$display("test %s failed with %0d errors", name, errors - errs_before);
		end
	endtask

	// holds the beat until a negedge shows it accepted.
	task automatic send_beat(input gfx_pkg::word d, input logic l);
		geom_tdata = d;
		geom_tlast = l;
		geom_tvalid = 1'b1;
		do
			@(negedge clk);
		while (!geom_tready);
		@(posedge clk);
		#2;
		geom_tvalid = 1'b0;
	endtask

	// ready three times in four under random back-pressure.
	always @(posedge clk) begin
		#2;
		if (bp_on) begin
			take_bits(2, bp_bits);
			raster_tready = |bp_bits[1:0];
		end else begin
			raster_tready = 1'b1;
		end
	end

	always @(negedge clk) begin
		if (rst_n && out_valid) begin
			ov_count++;
			if (sh_exp.size() == 0) begin
				errors++;
				$display("out_valid was high at cycle %0d with no operation in flight", cyc);
			end else begin
				cur_name = sh_name.pop_front();
				e0 = errors;
				compare_values({cur_name, " q"}, sh_exp.pop_front(), q);
				compare_values({cur_name, " cycle"}, 128'(sh_cyc.pop_front() + 2), 128'(cyc));
				finish_test(cur_name, e0);
			end
		end
	end

	always @(negedge clk) begin
		if (rst_n) begin
			if (stall_prev) begin
				compare_values({cur_name, " held tvalid"}, 128'(1), 128'(raster_tvalid));
				compare_values({cur_name, " held beat"}, 128'(held),
					128'({raster_tdata, raster_tlast}));
			end
			stall_prev = raster_tvalid && !raster_tready;
			held = {raster_tdata, raster_tlast};
			if (raster_tvalid && raster_tready) begin
				frag_got++;
				if (exp_frag.size() == 0) begin
					errors++;
					$display("%s produced an unexpected fragment %h", cur_name, raster_tdata);
				end else begin
					compare_values({cur_name, " fragment"}, 128'(exp_frag.pop_front()),
						128'(raster_tdata));
					compare_values({cur_name, " tlast"}, 128'(exp_frag.size() == 0),
						128'(raster_tlast));
				end
			end
			compare_values({cur_name, " geom_tready"}, 128'(!scan_flag), 128'(geom_tready));
			// scan window runs from the closing geometry beat to the last fragment.
			if (geom_tvalid && geom_tready) begin
				if (geom_tlast) begin
					scan_flag = gbeats > 0;
					scan_empty = cur_empty;
					gbeats = 0;
				end else begin
					gbeats++;
				end
			end else if (scan_flag && (scan_empty || (raster_tvalid && raster_tready
				&& raster_tlast))) begin
				scan_flag = 1'b0;
			end
		end
	end

	initial begin
		wd_cycles = SH_ROWS + RS_ROWS + 200;
		for (int i = 0; i < RS_ROWS; i++)
			wd_cycles += 4 * int'(RS_TAB[i].count);
		#(wd_cycles * PERIOD);
		$display("timeout: the tests did not finish within %0d clock periods", wd_cycles);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(posedge clk);
		#2;
		for (int i = 0; i < SH_ROWS; i++) begin
			op = SH_TAB[i].op;
			for (int l = 0; l < gfx_pkg::SHADER_LANES; l++) begin
				take_bits(32, ra);
				take_bits(32, rb);
				// spread leading-zero counts over the lanes.
				ra = ra >> (l * 7);
				if (l == 0 && !SH_TAB[i].rnd) begin
					ra = SH_TAB[i].a;
					rb = SH_TAB[i].b;
				end
				a[l] = ra;
				b[l] = rb;
				ev[l] = lane_ref(op, ra, rb);
			end
			in_valid = 1'b1;
			sh_exp.push_back(ev);
			sh_cyc.push_back(cyc);
			sh_name.push_back($sformatf("shader%0d_%s", i, op.name()));
			@(posedge clk);
			#2;
		end
		in_valid = 1'b0;
		while (sh_exp.size() != 0) begin
			@(posedge clk);
			#2;
		end
		compare_values("shader out_valid cycles", 128'(SH_ROWS), 128'(ov_count));

		bp_on = 1'b1;
		for (int i = 0; i < RS_ROWS; i++) begin
			cur_name = $sformatf("raster%0d", i);
			e0 = errors;
			frag_got = 0;
			rlo = RS_TAB[i].lo;
			rhi = RS_TAB[i].hi;
			cur_empty = rhi.x < rlo.x || rhi.y < rlo.y;
			if (!RS_TAB[i].first_last && !cur_empty)
				for (int y = int'(rlo.y); y <= int'(rhi.y); y++)
					for (int x = int'(rlo.x); x <= int'(rhi.x); x++)
						exp_frag.push_back({16'(y), 16'(x)});
			if (RS_TAB[i].first_last) begin
				send_beat(rlo, 1'b1);
			end else begin
				send_beat(rlo, 1'b0);
				send_beat(rhi, RS_TAB[i].fill == 0);
				for (int k = 0; k < int'(RS_TAB[i].fill); k++)
					send_beat(32'hf111_0000 + k, k == int'(RS_TAB[i].fill) - 1);
			end
			// the packet is done once geometry is taken again.
			do begin
				@(posedge clk);
				#1;
			end while (!geom_tready);
			#1;
			compare_values({cur_name, " fragments"}, 128'(RS_TAB[i].count), 128'(frag_got));
			finish_test(cur_name, e0);
		end
		bp_on = 1'b0;
		repeat (4) @(posedge clk);
		compare_values("raster leftover fragments", 128'(0), 128'(exp_frag.size()));

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks,
			errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* src/gfx_lane_alu.sv */
`timescale 1ns/1ps

module gfx_lane_alu (
	input  gfx_pkg::word        a,
	input  gfx_pkg::word        b,
	input  gfx_pkg::lane_opcode op,
	output gfx_pkg::word        q
);

	logic [gfx_pkg::SHIFT_BITS-1:0] shamt;
	logic                           a_lt_b;
	logic [gfx_pkg::CLZ_BITS-1:0]   lz;

	// an all-zero word counts 32 leading zeros.
	function automatic logic [gfx_pkg::CLZ_BITS-1:0] count_lz(input gfx_pkg::word v);
		logic [gfx_pkg::CLZ_BITS-1:0] n;
		logic                         seen;
		n = '0;
		seen = 1'b0;
		for (int i = gfx_pkg::WORD_BITS - 1; i >= 0; i--) begin
			if (v[i])
				seen = 1'b1;
			else if (!seen)
				n = n + 1'b1;
		end
		return n;
	endfunction

	assign shamt = b[gfx_pkg::SHIFT_BITS-1:0];
	assign a_lt_b = $signed(a) < $signed(b);
	assign lz = count_lz(a);

	always_comb begin
		unique case (op)
			gfx_pkg::OP_ADD:
				q = a + b;
			gfx_pkg::OP_SUB:
				q = a - b;
			gfx_pkg::OP_MIN:
				q = a_lt_b ? a : b;
			gfx_pkg::OP_MAX:
				q = a_lt_b ? b : a;
			// most negative value wraps to itself.
			gfx_pkg::OP_ABS:
				q = a[gfx_pkg::WORD_BITS-1] ? -a : a;
			gfx_pkg::OP_SHL:
				q = a << shamt;
			gfx_pkg::OP_SHR_U:
				q = a >> shamt;
			gfx_pkg::OP_SHR_S:
				q = $signed(a) >>> shamt;
			gfx_pkg::OP_CLZ:
				q = gfx_pkg::word'(lz);
			default:
				q = '0;
		endcase
	end

endmodule

/* src/gfx_pkg.sv */
package gfx_pkg;

	// lane and stream widths.
	localparam int SHADER_LANES = 4;
	localparam int WORD_BITS = 32;
	localparam int COORD_BITS = 16;
	localparam int SHIFT_BITS = 5;
	localparam int CLZ_BITS = 6;

	typedef logic [WORD_BITS-1:0] word;

	typedef word [SHADER_LANES-1:0] lane_vec;

	// one opcode applied to every lane.
	typedef enum logic [3:0] {
		OP_ADD,
		OP_SUB,
		OP_MIN,
		OP_MAX,
		OP_ABS,
		OP_SHL,
		OP_SHR_U,
		OP_SHR_S,
		OP_CLZ
	} lane_opcode;

	typedef struct packed {
		logic    valid;
		lane_vec lanes;
	} fpint_wb;

	typedef enum logic [1:0] {
		RS_IDLE,
		RS_CORNER,
		RS_DRAIN,
		RS_SCAN
	} raster_state;

	// y sits in the upper half of a stream word.
	typedef struct packed {
		logic [COORD_BITS-1:0] y;
		logic [COORD_BITS-1:0] x;
	} coord;

	typedef struct packed {
		word  tdata;
		logic tlast;
		logic tvalid;
	} pkt_beat;

endpackage

/* src/gfx_raster.sv */
`timescale 1ns/1ps

module gfx_raster (
	input  logic             clk,
	input  logic             rst_n,
	input  gfx_pkg::pkt_beat geometry,
	output logic             geom_tready,
	output gfx_pkg::pkt_beat coverage,
	input  logic             coverage_tready
);

	logic          load;
	logic          step;
	logic          emit;
	logic          emit_last;
	logic          empty;
	logic          at_end;
	logic          slot_free;
	gfx_pkg::coord lo;
	gfx_pkg::coord hi;
	gfx_pkg::coord pos;

	// output slot is free when empty or draining this cycle.
	assign slot_free = !coverage.tvalid || coverage_tready;

	always_ff @(posedge clk) begin
		if (!rst_n)
			coverage.tvalid <= 1'b0;
		else if (emit)
			coverage.tvalid <= 1'b1;
		else if (coverage_tready)
			coverage.tvalid <= 1'b0;
		if (emit) begin
			coverage.tdata <= pos;
			coverage.tlast <= emit_last;
		end
	end

	gfx_raster_fsm fsm (
		.clk,
		.rst_n,
		.geometry,
		.geom_tready,
		.load,
		.step,
		.lo,
		.hi,
		.empty,
		.at_end,
		.emit,
		.emit_last,
		.slot_free
	);

	gfx_raster_scan scan (
		.clk,
		.rst_n,
		.load,
		.lo,
		.hi,
		.step,
		.pos,
		.at_end,
		.empty
	);

	a_cov_hold: assert property (@(posedge clk) disable iff (!rst_n)
		coverage.tvalid && !coverage_tready |=> coverage.tvalid && $stable(coverage.tdata)
			&& $stable(coverage.tlast));

endmodule

/* src/gfx_raster_fsm.sv */
`timescale 1ns/1ps

module gfx_raster_fsm (
	input  logic             clk,
	input  logic             rst_n,
	input  gfx_pkg::pkt_beat geometry,
	output logic             geom_tready,
	output logic             load,
	output logic             step,
	output gfx_pkg::coord    lo,
	output gfx_pkg::coord    hi,
	input  logic             empty,
	input  logic             at_end,
	output logic             emit,
	output logic             emit_last,
	input  logic             slot_free
);

	gfx_pkg::raster_state state;
	gfx_pkg::raster_state state_next;
	gfx_pkg::coord        lo_q;
	gfx_pkg::coord        hi_q;
	logic                 last_sent;
	logic                 beat_ok;

	always_comb begin
		case (state)
			gfx_pkg::RS_SCAN:
				geom_tready = 1'b0;
			default:
				geom_tready = 1'b1;
		endcase
	end

	assign beat_ok = geometry.tvalid && geom_tready;

	// the closing beat of a packet starts the scan.
	assign load = beat_ok && geometry.tlast &&
		(state == gfx_pkg::RS_CORNER || state == gfx_pkg::RS_DRAIN);
	assign lo = lo_q;
	assign hi = (state == gfx_pkg::RS_CORNER) ? gfx_pkg::coord'(geometry.tdata) : hi_q;

	assign emit = state == gfx_pkg::RS_SCAN && !empty && !last_sent && slot_free;
	assign emit_last = at_end;
	assign step = emit && !at_end;

	always_comb begin
		state_next = state;
		case (state)
			gfx_pkg::RS_IDLE:
				if (beat_ok && !geometry.tlast)
					state_next = gfx_pkg::RS_CORNER;
			gfx_pkg::RS_CORNER:
				if (beat_ok)
					state_next = geometry.tlast ? gfx_pkg::RS_SCAN : gfx_pkg::RS_DRAIN;
			gfx_pkg::RS_DRAIN:
				if (beat_ok && geometry.tlast)
					state_next = gfx_pkg::RS_SCAN;
			// hold until the last fragment leaves the output slot.
			gfx_pkg::RS_SCAN:
				if (empty || (last_sent && slot_free))
					state_next = gfx_pkg::RS_IDLE;
			default:
				state_next = gfx_pkg::RS_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= gfx_pkg::RS_IDLE;
			last_sent <= 1'b0;
		end else begin
			state <= state_next;
			if (state_next != gfx_pkg::RS_SCAN)
				last_sent <= 1'b0;
			else if (emit && at_end)
				last_sent <= 1'b1;
		end
		if (beat_ok && state == gfx_pkg::RS_IDLE)
			lo_q <= geometry.tdata;
		if (beat_ok && state == gfx_pkg::RS_CORNER)
			hi_q <= geometry.tdata;
	end

	// no fragment follows the last one of a packet.
	a_single_last: assert property (@(posedge clk) disable iff (!rst_n)
		emit && emit_last |=> !emit);

endmodule

/* src/gfx_raster_scan.sv */
`timescale 1ns/1ps

module gfx_raster_scan (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          load,
	input  gfx_pkg::coord lo,
	input  gfx_pkg::coord hi,
	input  logic          step,
	output gfx_pkg::coord pos,
	output logic          at_end,
	output logic          empty
);

	gfx_pkg::coord lo_q;
	gfx_pkg::coord hi_q;
	logic          row_end;

	assign row_end = pos.x == hi_q.x;
	assign at_end = row_end && pos.y == hi_q.y;
	assign empty = hi_q.x < lo_q.x || hi_q.y < lo_q.y;

	always_ff @(posedge clk) begin
		if (load) begin
			lo_q <= lo;
			hi_q <= hi;
			pos <= lo;
		end else if (step) begin
			// wrap x back to the left edge on the next row.
			if (row_end) begin
				pos.x <= lo_q.x;
				pos.y <= pos.y + 1'b1;
			end else begin
				pos.x <= pos.x + 1'b1;
			end
		end
	end

	a_no_step_on_load: assert property (@(posedge clk) disable iff (!rst_n)
		!(step && load));

endmodule

/* src/gfx_shader_fpint.sv */
`timescale 1ns/1ps

module gfx_shader_fpint (
	input  logic                clk,
	input  logic                rst_n,
	input  gfx_pkg::lane_opcode op,
	input  logic                in_valid,
	input  gfx_pkg::lane_vec    a,
	input  gfx_pkg::lane_vec    b,
	output gfx_pkg::fpint_wb    wb
);

	gfx_pkg::lane_opcode op_q;
	gfx_pkg::lane_vec    a_q;
	gfx_pkg::lane_vec    b_q;
	gfx_pkg::lane_vec    res;
	logic                valid_q;

	// stage one.
	always_ff @(posedge clk) begin
		if (!rst_n)
			valid_q <= 1'b0;
		else
			valid_q <= in_valid;
		op_q <= op;
		a_q <= a;
		b_q <= b;
	end

	for (genvar i = 0; i < gfx_pkg::SHADER_LANES; i++) begin : g_lane
		gfx_lane_alu alu (
			.a (a_q[i]),
			.b (b_q[i]),
			.op(op_q),
			.q (res[i])
		);
	end

	// stage two is the writeback register.
	always_ff @(posedge clk) begin
		if (!rst_n)
			wb.valid <= 1'b0;
		else
			wb.valid <= valid_q;
		wb.lanes <= res;
	end

	a_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> op inside {gfx_pkg::OP_ADD, gfx_pkg::OP_SUB, gfx_pkg::OP_MIN,
			gfx_pkg::OP_MAX, gfx_pkg::OP_ABS, gfx_pkg::OP_SHL, gfx_pkg::OP_SHR_U,
			gfx_pkg::OP_SHR_S, gfx_pkg::OP_CLZ});

	a_wb_latency: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |=> ##1 wb.valid);

	a_wb_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
		!in_valid |=> ##1 !wb.valid);

endmodule

/* src/w3d_top.sv */
`timescale 1ns/1ps

module w3d_top (
	input  logic                clk,
	input  logic                rst_n,

	input  gfx_pkg::lane_vec    a,
	input  gfx_pkg::lane_vec    b,
	input  gfx_pkg::lane_opcode op,
	input  logic                in_valid,
	output logic                out_valid,
	output gfx_pkg::lane_vec    q,

	input  gfx_pkg::word        geom_tdata,
	input  logic                geom_tlast,
	input  logic                geom_tvalid,
	output logic                geom_tready,

	input  logic                raster_tready,
	output gfx_pkg::word        raster_tdata,
	output logic                raster_tlast,
	output logic                raster_tvalid
);

	gfx_pkg::fpint_wb fpint_wb;
	gfx_pkg::pkt_beat geometry;
	gfx_pkg::pkt_beat coverage;

	assign out_valid = fpint_wb.valid;
	assign q = fpint_wb.lanes;

	assign geometry.tdata = geom_tdata;
	assign geometry.tlast = geom_tlast;
	assign geometry.tvalid = geom_tvalid;

	assign raster_tdata = coverage.tdata;
	assign raster_tlast = coverage.tlast;
	assign raster_tvalid = coverage.tvalid;

	gfx_shader_fpint fpint (
		.clk,
		.rst_n,
		.op,
		.in_valid,
		.a,
		.b,
		.wb(fpint_wb)
	);

	gfx_raster raster (
		.clk,
		.rst_n,
		.geometry,
		.geom_tready,
		.coverage,
		.coverage_tready(raster_tready)
	);

endmodule
